//--- lightCore.f
logic/lightPkg.sv
logic/lightAlu.sv
logic/lightRegFile.sv
logic/lightMemory.sv
logic/lightOutPort.sv
logic/lightSequencer.sv
logic/lightTop.sv
sim/lightTb_chk.sv
sim/lightTb.sv

//--- Bender.yml
package:
  name: lightCore

sources:
  - files:
      - logic/lightPkg.sv
      - logic/lightAlu.sv
      - logic/lightRegFile.sv
      - logic/lightMemory.sv
      - logic/lightOutPort.sv
      - logic/lightSequencer.sv
      - logic/lightTop.sv
  - target: simulation
    files:
      - sim/lightTb_chk.sv
      - sim/lightTb.sv

//--- sim/lightStim.txt
# Columns: command letter, then hex fields
# L addr word = load, R cycles = run with timeout per value, E value = expected LED, S = stop
# Counter with addi, sli, port store and jmp
L 00 80200001
L 01 d841001f
L 02 80600000
L 03 e8430000
L 04 80630001
L 05 43fffffd
R 80
E 0
E 1
E 2
E 3
S
# Sum loop 15 down to 1, restart at address 0
L 00 8020000f
L 01 80400000
L 02 80a00001
L 03 d8a5001f
L 04 00420800
L 05 84210001
L 06 00610008
L 07 f403fffc
L 08 e8a20000
L 09 43ffffff
R 400
E 78
S
# Register and, or, xor, sub, sll, srl on f0 and 3c
L 00 802000f0
L 01 8040003c
L 02 80600004
L 03 80a00001
L 04 d8a5001f
L 05 00811002
L 06 e8a40000
L 07 00811003
L 08 e8a40000
L 09 00811004
L 0a e8a40000
L 0b 00820801
L 0c e8a40000
L 0d 00811805
L 0e e8a40000
L 0f 00811806
L 10 e8a40000
L 11 43ffffff
R 80
E 30
E fc
E cc
E ffffff4c
E f00
E f
S
# Memory round trip, word at 28 placed by the load port
L 28 12345678
L 00 80a00001
L 01 d8a5001f
L 02 e4200028
L 03 e8a10000
L 04 8040ffa5
L 05 e8020029
L 06 e4800029
L 07 e8a40000
L 08 43ffffff
R 80
E 12345678
E ffffffa5
S

//--- sim/lightTb.sv
`timescale 1ns/100ps
`default_nettype none

module lightTb;

    localparam int memAddrWidth = 6;
    localparam int settleCycles = 12;  // Longer than any instruction

    logic                     Clock;
    logic                     arstN;
    logic                     run;
    logic                     loadEn;
    logic [memAddrWidth-1:0]  loadAddr;
    logic [31:0]              loadData;
    logic [31:0]              ledOut;
    logic                     ledStrobe;

    int  mismatchCount;
    int  otherCount;
    int  timeoutCycles;  // Per LED value and set by each run command
    bit  quiet;          // Core held idle so no LED update allowed
    bit  aborted;

    lightTop #(
        .memAddrWidth (memAddrWidth)
    ) UUT (
        .Clock, .arstN, .run,
        .loadEn, .loadAddr, .loadData,
        .ledOut, .ledStrobe
    );

    bind lightSequencer lightTb_chk seqChk (
        .Clock (Clock), .arstN (arstN),
        .memRead (memRead), .memWrite (memWrite), .readDone (readDone),
        .portWrite (portWrite), .wrEn (wrEn)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    always @(negedge Clock) begin
        if (quiet && ledStrobe) begin
            $display("LED strobe at %0t while run was low", $time);
            otherCount++;
        end
    end

    task automatic loadWord(input logic [memAddrWidth-1:0] addr, input logic [31:0] data);
        loadEn   = 1'b1;
        loadAddr = addr;
        loadData = data;
        @(posedge Clock);
        #2;
        loadEn = 1'b0;
    endtask

    task automatic startRun(input int cycles);
        timeoutCycles = cycles;
        quiet         = 1'b0;
        run           = 1'b1;
    endtask

    // Lets the current instruction finish before the core sits idle
    task automatic stopRun();
        run = 1'b0;
        repeat (settleCycles) @(posedge Clock);
        #2;
        quiet = 1'b1;
    endtask

    task automatic expectLed(input logic [31:0] expected);
        int waited;
        waited = 0;
        do begin
            @(negedge Clock);
            waited++;
        end while (ledStrobe !== 1'b1 && waited < timeoutCycles);
        if (ledStrobe !== 1'b1) begin
            $display("timeout after %0d cycles waiting for LED value %h", waited, expected);
            otherCount++;
            aborted = 1'b1;
        end else if (ledOut !== expected) begin
            $display("mismatch at %0t: ledOut %h, expected %h", $time, ledOut, expected);
            mismatchCount++;
        end
        @(posedge Clock);
        #2;
    endtask

    initial begin
        int           fd;
        int           fields;
        string        line;
        byte          cmd;
        logic [31:0]  argA;
        logic [31:0]  argB;

        arstN         = 1'b0;
        run           = 1'b0;
        loadEn        = 1'b0;
        loadAddr      = '0;
        loadData      = '0;
        mismatchCount = 0;
        otherCount    = 0;
        timeoutCycles = 100;
        quiet         = 1'b1;
        aborted       = 1'b0;
        repeat (4) @(posedge Clock);
        #2;
        arstN = 1'b1;

        fd = $fopen("sim/lightStim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file sim/lightStim.txt");
            otherCount++;
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line   = "";
            fields = $fgets(line, fd);
            if (fields > 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%c %h %h", cmd, argA, argB);
                case (cmd)
                    "L":     loadWord(argA[memAddrWidth-1:0], argB);
                    "R":     startRun(argA);
                    "E":     expectLed(argA);
                    "S":     stopRun();
                    default: begin
                        $display("unknown command in stimulus line: %s", line);
                        otherCount++;
                    end
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("error counts: %0d mismatches, %0d other", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/lightTb_chk.sv
`timescale 1ns/100ps
`default_nettype none

module lightTb_chk (
    input  wire logic  Clock,
    input  wire logic  arstN,
    input  wire logic  memRead,
    input  wire logic  memWrite,
    input  wire logic  readDone,
    input  wire logic  portWrite,
    input  wire logic  wrEn
);

    noReadWrite: assert property (@(posedge Clock) disable iff (!arstN)
        !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    // Memory answers every read on the next clock
    readAnswered: assert property (@(posedge Clock) disable iff (!arstN)
        memRead |=> readDone)
        else $error("memRead not followed by readDone one cycle later");

    noMemAndPort: assert property (@(posedge Clock) disable iff (!arstN)
        !(memWrite && portWrite))
        else $error("memWrite and portWrite high in the same cycle");

    noWriteInReset: assert property (@(posedge Clock) !arstN |-> !wrEn)
        else $error("wrEn high while reset is asserted");

endmodule

`default_nettype wire

//--- logic/lightTop.sv
`timescale 1ns/100ps
`default_nettype none

module lightTop #(
    parameter int memAddrWidth = 6  // 64 words
) (
    input  wire logic                            Clock,
    input  wire logic                            arstN,
    input  wire logic                            run,
    input  wire logic                            loadEn,
    input  wire logic [memAddrWidth-1:0]         loadAddr,
    input  wire logic [lightPkg::dataWidth-1:0]  loadData,
    output logic [lightPkg::dataWidth-1:0]       ledOut,
    output logic                                 ledStrobe
);

    logic                            memRead, memWrite;
    logic [memAddrWidth-1:0]         memAddr;
    logic [lightPkg::dataWidth-1:0]  memWData, readData;
    logic                            readDone, writeDone;
    logic                            portWrite;
    logic [lightPkg::dataWidth-1:0]  portData;
    logic [4:0]                      rdAddrA, rdAddrB, wrAddr;
    logic [lightPkg::dataWidth-1:0]  rdDataA, rdDataB, wrData;
    logic                            wrEn;
    lightPkg::aluOpT                 aluOp;
    logic [lightPkg::dataWidth-1:0]  opA, opB, result;
    logic                            zero;

    lightSequencer #(
        .memAddrWidth (memAddrWidth)
    ) sequencer (
        .Clock, .arstN, .run,
        .memRead, .memWrite, .memAddr, .memWData,
        .readData, .readDone, .writeDone,
        .portWrite, .portData,
        .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
        .wrEn, .wrAddr, .wrData,
        .aluOp, .opA, .opB, .result, .zero
    );

    lightRegFile regFile (
        .Clock, .arstN,
        .rdAddrA, .rdAddrB,
        .wrEn, .wrAddr, .wrData,
        .rdDataA, .rdDataB
    );

    lightAlu alu (
        .aluOp, .opA, .opB,
        .result, .zero
    );

    // Program and data share this memory
    lightMemory #(
        .memAddrWidth (memAddrWidth)
    ) memory (
        .Clock, .arstN,
        .memRead, .memWrite, .memAddr, .memWData,
        .loadEn, .loadAddr, .loadData,
        .readData, .readDone, .writeDone
    );

    lightOutPort outPort (
        .Clock, .arstN,
        .portWrite, .portData,
        .ledOut, .ledStrobe
    );

endmodule

`default_nettype wire

//--- logic/lightSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module lightSequencer #(
    parameter int memAddrWidth = 6
) (
    input  wire logic                            Clock,
    input  wire logic                            arstN,
    input  wire logic                            run,
    output logic                                 memRead,
    output logic                                 memWrite,
    output logic [memAddrWidth-1:0]              memAddr,
    output logic [lightPkg::dataWidth-1:0]       memWData,
    input  wire logic [lightPkg::dataWidth-1:0]  readData,
    input  wire logic                            readDone,
    input  wire logic                            writeDone,
    output logic                                 portWrite,
    output logic [lightPkg::dataWidth-1:0]       portData,
    output logic [4:0]                           rdAddrA,
    output logic [4:0]                           rdAddrB,
    input  wire logic [lightPkg::dataWidth-1:0]  rdDataA,
    input  wire logic [lightPkg::dataWidth-1:0]  rdDataB,
    output logic                                 wrEn,
    output logic [4:0]                           wrAddr,
    output logic [lightPkg::dataWidth-1:0]       wrData,
    output lightPkg::aluOpT                      aluOp,
    output logic [lightPkg::dataWidth-1:0]       opA,
    output logic [lightPkg::dataWidth-1:0]       opB,
    input  wire logic [lightPkg::dataWidth-1:0]  result,
    input  wire logic                            zero
);

    localparam logic [2:0] sIdle = 3'd0, sFetchReq = 3'd1, sFetchWait = 3'd2, sDecode = 3'd3;
    localparam logic [2:0] sExecute = 3'd4, sMemReq = 3'd5, sMemWait = 3'd6, sWriteback = 3'd7;

    logic [2:0]                      state;
    logic [memAddrWidth-1:0]         pc;
    lightPkg::instrT                 ir;
    logic [lightPkg::dataWidth-1:0]  regA, regB;  // Operands latched in decode
    logic [lightPkg::dataWidth-1:0]  resultReg;   // ALU result or load data
    lightPkg::opcodeT                opcode;
    logic                            isLoad, isStore, isJmp, isBez, isAlu;
    logic                            portSel, memDone, endInstr;
    logic [lightPkg::dataWidth-1:0]  immExt, jmpOff;
    logic [memAddrWidth-1:0]         pcPlus1, pcNext;

    assign opcode  = ir.immView.opcode;
    assign isLoad  = (opcode == lightPkg::opLoad);
    assign isStore = (opcode == lightPkg::opStore);
    assign isJmp   = (opcode == lightPkg::opJmp);
    assign isBez   = (opcode == lightPkg::opBez);
    assign isAlu   = (opcode == lightPkg::opReg) || (opcode == lightPkg::opAddi) ||
                     (opcode == lightPkg::opSubi) || (opcode == lightPkg::opSli);

    assign immExt = {{16{ir.immView.imm[15]}}, ir.immView.imm};
    assign jmpOff = {{6{ir.immView.rd[4]}}, ir.immView.rd, ir.immView.rs1, ir.immView.imm};

    // Branch and jump targets are relative to the next instruction
    assign pcPlus1 = pc + 1'b1;
    always_comb begin
        if (isJmp)
            pcNext = pcPlus1 + jmpOff[memAddrWidth-1:0];
        else if (isBez && zero)
            pcNext = pcPlus1 + immExt[memAddrWidth-1:0];
        else
            pcNext = pcPlus1;
    end

    // Store takes base from rd and data from rs1
    assign rdAddrA = isStore ? ir.immView.rd : ir.regView.rs1;
    assign rdAddrB = isStore ? ir.regView.rs1 : ir.regView.rs2;

    assign opA = regA;
    always_comb begin
        case (opcode)
            lightPkg::opReg:  opB = regB;
            lightPkg::opBez:  opB = '0;  // Pass rs1 through so zero flag decides
            default:          opB = immExt;
        endcase
    end

    always_comb begin
        case (opcode)
            lightPkg::opReg:  aluOp = lightPkg::aluOpT'(ir.regView.func[3:0]);
            lightPkg::opSubi: aluOp = lightPkg::aluSub;
            lightPkg::opSli:  aluOp = lightPkg::aluSll;
            lightPkg::opBez:  aluOp = lightPkg::aluOr;
            default:          aluOp = lightPkg::aluAdd;  // Addi and address calc
        endcase
    end

    // Memory and port requests
    assign portSel   = resultReg[lightPkg::portAddrBit];
    assign memRead   = (state == sFetchReq) || (state == sMemReq && isLoad);
    assign memWrite  = (state == sMemReq) && isStore && !portSel;
    assign portWrite = (state == sMemReq) && isStore && portSel;
    assign memAddr   = (state == sFetchReq) ? pc : resultReg[memAddrWidth-1:0];
    assign memWData  = regB;
    assign portData  = regB;
    assign memDone   = isLoad ? readDone : (portSel || writeDone);  // Port has no done

    assign wrEn   = (state == sWriteback);
    assign wrAddr = ir.regView.rd;
    assign wrData = resultReg;

    assign endInstr = (state == sExecute && !isAlu && !isLoad && !isStore) ||
                      (state == sMemWait && isStore && memDone) ||
                      (state == sWriteback);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state <= sIdle;
            pc    <= '0;
        end else begin
            case (state)
                sIdle:      if (run) state <= sFetchReq;
                sFetchReq:  state <= sFetchWait;
                sFetchWait: if (readDone) state <= sDecode;
                sDecode:    state <= sExecute;
                sExecute: begin
                    pc <= pcNext;
                    if (isLoad || isStore)
                        state <= sMemReq;
                    else if (isAlu)
                        state <= sWriteback;
                end
                sMemReq:    state <= sMemWait;
                sMemWait:   if (isLoad && memDone) state <= sWriteback;
                default:    ;  // Writeback only ends the instruction
            endcase
            if (endInstr) begin
                state <= run ? sFetchReq : sIdle;
                if (!run)
                    pc <= '0;  // Restart program from address 0
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (state == sFetchWait && readDone)
            ir <= readData;
        if (state == sDecode) begin
            regA <= rdDataA;
            regB <= rdDataB;
        end
        if (state == sExecute)
            resultReg <= result;
        else if (state == sMemWait && isLoad && readDone)
            resultReg <= readData;
    end

endmodule

`default_nettype wire

//--- logic/lightOutPort.sv
`timescale 1ns/100ps
`default_nettype none

module lightOutPort (
    input  wire logic                            Clock,
    input  wire logic                            arstN,
    input  wire logic                            portWrite,
    input  wire logic [lightPkg::dataWidth-1:0]  portData,
    output logic [lightPkg::dataWidth-1:0]       ledOut,
    output logic                                 ledStrobe
);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ledOut    <= '0;  // LEDs dark after reset
            ledStrobe <= 1'b0;
        end else begin
            if (portWrite)
                ledOut <= portData;
            ledStrobe <= portWrite;  // Marks a fresh value
        end
    end

endmodule

`default_nettype wire

//--- logic/lightMemory.sv
`timescale 1ns/100ps
`default_nettype none

module lightMemory #(
    parameter int memAddrWidth = 6
) (
    input  wire logic                            Clock,
    input  wire logic                            arstN,
    input  wire logic                            memRead,
    input  wire logic                            memWrite,
    input  wire logic [memAddrWidth-1:0]         memAddr,
    input  wire logic [lightPkg::dataWidth-1:0]  memWData,
    input  wire logic                            loadEn,
    input  wire logic [memAddrWidth-1:0]         loadAddr,
    input  wire logic [lightPkg::dataWidth-1:0]  loadData,
    output logic [lightPkg::dataWidth-1:0]       readData,
    output logic                                 readDone,
    output logic                                 writeDone
);

    logic [lightPkg::dataWidth-1:0] mem [2**memAddrWidth];

    // Single write port where the program loader has priority
    always_ff @(posedge Clock) begin
        if (loadEn)
            mem[loadAddr] <= loadData;
        else if (memWrite)
            mem[memAddr] <= memWData;
        if (memRead)
            readData <= mem[memAddr];
    end

    // One-cycle done pulses one clock after the strobe
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            readDone  <= 1'b0;
            writeDone <= 1'b0;
        end else begin
            readDone  <= memRead;
            writeDone <= memWrite;
        end
    end

endmodule

`default_nettype wire

//--- logic/lightRegFile.sv
`timescale 1ns/100ps
`default_nettype none

module lightRegFile (
    input  wire logic                            Clock,
    input  wire logic                            arstN,
    input  wire logic [4:0]                      rdAddrA,
    input  wire logic [4:0]                      rdAddrB,
    input  wire logic                            wrEn,
    input  wire logic [4:0]                      wrAddr,
    input  wire logic [lightPkg::dataWidth-1:0]  wrData,
    output logic [lightPkg::dataWidth-1:0]       rdDataA,
    output logic [lightPkg::dataWidth-1:0]       rdDataB
);

    logic [lightPkg::dataWidth-1:0] regs [32];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wrEn && wrAddr != 5'd0) begin  // R0 stays zero
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous read ports
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

//--- logic/lightAlu.sv
`timescale 1ns/100ps
`default_nettype none

module lightAlu (
    input  wire lightPkg::aluOpT                 aluOp,
    input  wire logic [lightPkg::dataWidth-1:0]  opA,
    input  wire logic [lightPkg::dataWidth-1:0]  opB,
    output logic [lightPkg::dataWidth-1:0]       result,
    output logic                                 zero
);

    logic [4:0] shamt;

    assign shamt = opB[4:0];  // Shifts use low 5 bits only

    always_comb begin
        case (aluOp)
            lightPkg::aluAdd: result = opA + opB;
            lightPkg::aluSub: result = opA - opB;
            lightPkg::aluAnd: result = opA & opB;
            lightPkg::aluOr:  result = opA | opB;
            lightPkg::aluXor: result = opA ^ opB;
            lightPkg::aluSll: result = opA << shamt;
            lightPkg::aluSrl: result = opA >> shamt;  // Logical with zero fill
            lightPkg::aluCe: begin
                result    = '0;
                result[0] = (opA == opB);
            end
            default:          result = '0;
        endcase
    end

    // Used by bez, which passes rs1 through the OR path
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- logic/lightPkg.sv
`default_nettype none

package lightPkg;

    localparam int dataWidth = 32;  // Data and instruction word

    // Primary opcodes in bits 31:26
    typedef enum logic [5:0] {
        opReg   = 6'b000000,  // Register ALU group with op in function field
        opJmp   = 6'b010000,
        opAddi  = 6'b100000,
        opSubi  = 6'b100001,
        opSli   = 6'b110110,
        opLoad  = 6'b111001,
        opStore = 6'b111010,
        opBez   = 6'b111101
    } opcodeT;

    // Matches the function field of register instructions
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSll = 4'd5,
        aluSrl = 4'd6,
        aluCe  = 4'd8   // Compare equal gives 1 or 0
    } aluOpT;

    // Register form computes rd = rs1 op rs2
    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [10:0] func;  // Only low 4 bits decoded
    } regFieldsT;

    // Immediate form used also by load, store and bez
    typedef struct packed {
        opcodeT             opcode;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic signed [15:0] imm;
    } immFieldsT;

    // Jump offset spans rd, rs1 and imm of the immediate view
    typedef union packed {
        regFieldsT regView;
        immFieldsT immView;
    } instrT;

    // Stores with this address bit set go to the LED port
    localparam int portAddrBit = 31;

endpackage

`default_nettype wire
